// File: hdl/lsu_defs.svh
// Widths and depths shared by the D$ tag lookup stage and its MSHQ
// Include in any file that sizes a port, a field or a queue
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// Operation word widths
`define LSU_ADDR_WIDTH 32
`define LSU_TAG_WIDTH 6

// D$ geometry, 2-way with 16 sets of 32-byte lines
`define DC_BLOCK_WIDTH 5
`define DC_INDEX_WIDTH 4
`define DC_WAY_WIDTH 1

// Address bits above index and offset
`define DC_TAG_WIDTH 23

// Miss queue size
`define MSHQ_DEPTH 4
`define MSHQ_PTR_WIDTH 2

`endif

// File: hdl/lsu_pkg.sv
// Types shared by the load/store unit tag lookup blocks
// Referenced by scoped name from the RTL and the testbench
`include "lsu_defs.svh"

package lsu_pkg;

    // Memory operation function code
    typedef enum logic [1:0] {
        lsu_load     = 2'd0,
        lsu_store    = 2'd1,
        lsu_prefetch = 2'd2,
        lsu_none     = 2'd3
    } lsu_func_t;

    // Address word, either raw or split for the D$
    typedef union packed {
        logic [`LSU_ADDR_WIDTH-1:0] raw;
        struct packed {
            logic [`DC_TAG_WIDTH-1:0]   dc_tag;
            logic [`DC_INDEX_WIDTH-1:0] dc_index;
            logic [`DC_BLOCK_WIDTH-1:0] dc_offset;
        } fields;
    } dc_addr_t;

    // Result of one lookup
    typedef enum logic [1:0] {
        out_hit    = 2'd0,
        out_merged = 2'd1,
        out_miss   = 2'd2,
        out_replay = 2'd3
    } lsu_outcome_t;

endpackage

// File: hdl/lsu_ifs.sv
// Interfaces between the hit stage and the tag array and the miss queue
// Both return their results combinationally in the cycle of the request
`timescale 1ns/1ps
`include "lsu_defs.svh"

interface dc_tag_if;
    logic [`DC_INDEX_WIDTH-1:0] index;
    logic [`DC_TAG_WIDTH-1:0]   tag;
    logic                       hit;
    logic [`DC_WAY_WIDTH-1:0]   way;

    modport lookup (output index, output tag, input hit, input way);
    modport array (input index, input tag, output hit, output way);
endinterface

interface mshq_if;
    // Line is the address tag followed by the set index
    logic [`DC_TAG_WIDTH+`DC_INDEX_WIDTH-1:0] line;
    logic                                     match;
    logic                                     full;
    logic                                     enq_en;
    lsu_pkg::lsu_func_t                       enq_func;
    logic [`LSU_ADDR_WIDTH-1:0]               enq_addr;
    logic [`LSU_TAG_WIDTH-1:0]                enq_tag;

    modport requester (
        output line, output enq_en, output enq_func, output enq_addr, output enq_tag,
        input match, input full
    );
    modport queue (
        input line, input enq_en, input enq_func, input enq_addr, input enq_tag,
        output match, output full
    );
endinterface

// File: hdl/dc_tag_array.sv
// D$ tag memory with valid bits, 2 ways by 16 sets, held in flops
// Lookup port answers in the same cycle, APB slave reads and writes single entries
`timescale 1ns/1ps
`include "lsu_defs.svh"

module dc_tag_array (
    input  logic        clk,
    input  logic        i_reset,

    // APB slave for tag maintenance
    input  logic        i_psel,
    input  logic        i_penable,
    input  logic        i_pwrite,
    input  logic [11:0] i_paddr,
    input  logic [31:0] i_pwdata,
    output logic [31:0] o_prdata,
    output logic        o_pready,

    // Lookup from the hit stage
    dc_tag_if.array     tag
);

    localparam int num_sets = 1 << `DC_INDEX_WIDTH;
    localparam int num_ways = 1 << `DC_WAY_WIDTH;

    logic [num_sets-1:0][num_ways-1:0] valid_q;
    logic [`DC_TAG_WIDTH-1:0]          tag_q [num_sets][num_ways];

    logic [`DC_INDEX_WIDTH-1:0] apb_index;
    logic [`DC_WAY_WIDTH-1:0]   apb_way;
    logic                       apb_write;
    logic [num_ways-1:0]        way_match;

    // Word addressed entries, set in bits 5:2 and way in bit 6
    assign apb_index = i_paddr[`DC_INDEX_WIDTH+1:2];
    assign apb_way   = i_paddr[`DC_INDEX_WIDTH+2 +: `DC_WAY_WIDTH];

    // Write commits at the end of the access phase
    assign apb_write = i_psel && i_penable && i_pwrite;

    // No wait states
    assign o_pready = 1'b1;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            valid_q <= '0;
        end else if (apb_write) begin
            valid_q[apb_index][apb_way] <= i_pwdata[31];
        end
    end

    always_ff @(posedge clk) begin
        if (apb_write) begin
            tag_q[apb_index][apb_way] <= i_pwdata[`DC_TAG_WIDTH-1:0];
        end
    end

    // Read data uses the write format, valid in bit 31 and tag in the low bits
    always_comb begin
        o_prdata = '0;
        o_prdata[31] = valid_q[apb_index][apb_way];
        o_prdata[`DC_TAG_WIDTH-1:0] = tag_q[apb_index][apb_way];
    end

    // Compare every way of the indexed set
    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            way_match[w] = valid_q[tag.index][w] && (tag_q[tag.index][w] == tag.tag);
        end
    end

    assign tag.hit = |way_match;

    always_comb begin
        tag.way = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (way_match[w]) begin
                tag.way = `DC_WAY_WIDTH'(w);
            end
        end
    end

    // Software must never place one line in two ways of a set
    a_single_way_match: assert property (
        @(posedge clk) disable iff (i_reset)
        $onehot0(way_match)
    ) else $error("dc_tag_array: line valid in more than one way of set %0d", tag.index);

endmodule

// File: hdl/mshq.sv
// Miss status holding queue, four entries kept as a circular buffer
// Reports a pending line to the hit stage and sends misses to memory oldest first
`timescale 1ns/1ps
`include "lsu_defs.svh"

module mshq (
    input  logic                       clk,
    input  logic                       i_reset,

    // Request port to memory
    output logic                       o_miss_valid,
    output lsu_pkg::lsu_func_t         o_miss_func,
    output logic [`LSU_ADDR_WIDTH-1:0] o_miss_addr,
    output logic [`LSU_TAG_WIDTH-1:0]  o_miss_tag,
    input  logic                       i_miss_ready,

    // Search and enqueue from the hit stage
    mshq_if.queue                      q
);

    localparam int line_lsb = `DC_BLOCK_WIDTH;

    logic [`MSHQ_PTR_WIDTH-1:0] head_q;
    logic [`MSHQ_PTR_WIDTH-1:0] tail_q;
    logic [`MSHQ_PTR_WIDTH:0]   count_q;
    logic [`MSHQ_DEPTH-1:0]     ent_valid_q;

    // Entry payload
    lsu_pkg::lsu_func_t         ent_func_q [`MSHQ_DEPTH];
    logic [`LSU_ADDR_WIDTH-1:0] ent_addr_q [`MSHQ_DEPTH];
    logic [`LSU_TAG_WIDTH-1:0]  ent_tag_q  [`MSHQ_DEPTH];

    logic                       xfer;
    logic [`MSHQ_DEPTH-1:0]     ent_match;

    assign q.full = (count_q == (`MSHQ_PTR_WIDTH+1)'(`MSHQ_DEPTH));

    // Line compare over every occupied entry
    always_comb begin
        for (int i = 0; i < `MSHQ_DEPTH; i++) begin
            ent_match[i] = ent_valid_q[i] &&
                (ent_addr_q[i][`LSU_ADDR_WIDTH-1:line_lsb] == q.line);
        end
    end

    assign q.match = |ent_match;

    // Head of the queue goes to memory
    assign o_miss_valid = ent_valid_q[head_q];
    assign o_miss_func  = ent_func_q[head_q];
    assign o_miss_addr  = ent_addr_q[head_q];
    assign o_miss_tag   = ent_tag_q[head_q];

    assign xfer = o_miss_valid && i_miss_ready;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            head_q      <= '0;
            tail_q      <= '0;
            count_q     <= '0;
            ent_valid_q <= '0;
        end else begin
            if (q.enq_en) begin
                ent_valid_q[tail_q] <= 1'b1;
                tail_q              <= tail_q + 1'b1;
            end
            // Head and tail only coincide when empty or full, so no clash here
            if (xfer) begin
                ent_valid_q[head_q] <= 1'b0;
                head_q              <= head_q + 1'b1;
            end
            case ({q.enq_en, xfer})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (q.enq_en) begin
            ent_func_q[tail_q] <= q.enq_func;
            ent_addr_q[tail_q] <= q.enq_addr;
            ent_tag_q[tail_q]  <= q.enq_tag;
        end
    end

    // Hit stage must turn a miss into a replay when the queue is full
    a_no_enq_when_full: assert property (
        @(posedge clk) disable iff (i_reset)
        q.enq_en |-> !q.full
    ) else $error("mshq: enqueue while full");

    // A stalled request holds until memory takes it
    a_miss_stable: assert property (
        @(posedge clk) disable iff (i_reset)
        (o_miss_valid && !i_miss_ready) |=>
            (o_miss_valid && $stable(o_miss_addr) && $stable(o_miss_tag) &&
             $stable(o_miss_func))
    ) else $error("mshq: miss request changed while stalled");

endmodule

// File: hdl/lsu_hit.sv
// Hit stage of the LSU that looks up the D$ tags and the MSHQ in one cycle
// Registers one outcome per operation and sends primary misses to the MSHQ
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_hit (
    input  logic                       clk,
    input  logic                       i_reset,

    // Operation from the previous LSU stage
    input  logic                       i_valid,
    input  lsu_pkg::lsu_func_t         i_func,
    input  lsu_pkg::dc_addr_t          i_addr,
    input  logic [`LSU_TAG_WIDTH-1:0]  i_tag,

    // Result to the next LSU stage
    output logic                       o_valid,
    output lsu_pkg::lsu_outcome_t      o_outcome,
    output logic [`DC_WAY_WIDTH-1:0]   o_way,
    output lsu_pkg::lsu_func_t         o_func,
    output logic [`LSU_ADDR_WIDTH-1:0] o_addr,
    output logic [`LSU_TAG_WIDTH-1:0]  o_tag,

    dc_tag_if.lookup                   dc,
    mshq_if.requester                  mq
);

    lsu_pkg::lsu_outcome_t outcome;
    logic                  enq;

    // Same line address feeds both lookups
    assign dc.index = i_addr.fields.dc_index;
    assign dc.tag   = i_addr.fields.dc_tag;
    assign mq.line  = {i_addr.fields.dc_tag, i_addr.fields.dc_index};

    // Priority is hit, then pending line, then queue space
    always_comb begin
        outcome = lsu_pkg::out_miss;
        enq     = 1'b0;
        if (dc.hit) begin
            outcome = lsu_pkg::out_hit;
        end else if (mq.match) begin
            outcome = lsu_pkg::out_merged;
        end else if (mq.full) begin
            outcome = lsu_pkg::out_replay;
        end else begin
            enq = i_valid;
        end
    end

    // Primary miss is written into the MSHQ at the edge that registers the result
    assign mq.enq_en   = enq;
    assign mq.enq_func = i_func;
    assign mq.enq_addr = i_addr.raw;
    assign mq.enq_tag  = i_tag;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge clk) begin
        o_outcome <= outcome;
        o_way     <= dc.way;
        o_func    <= i_func;
        o_addr    <= i_addr.raw;
        o_tag     <= i_tag;
    end

    // A line just sent to the MSHQ is already pending for the next lookup of it
    a_enq_seen_next: assert property (
        @(posedge clk) disable iff (i_reset)
        mq.enq_en |=>
            (!(i_valid && mq.line == $past(mq.line)) || mq.match || dc.hit)
    ) else $error("lsu_hit: line just enqueued not seen by the next lookup");

endmodule

// File: hdl/lsu_dcache_lookup.sv
// Top level of the D$ tag lookup stage of the load/store unit
// Wires the hit stage to the tag array and the MSHQ, with APB and miss ports
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_dcache_lookup (
    input  logic                       clk,
    input  logic                       i_reset,

    // Operation in
    input  logic                       i_valid,
    input  lsu_pkg::lsu_func_t         i_func,
    input  logic [`LSU_ADDR_WIDTH-1:0] i_addr,
    input  logic [`LSU_TAG_WIDTH-1:0]  i_tag,

    // Result out, one cycle later
    output logic                       o_valid,
    output lsu_pkg::lsu_outcome_t      o_outcome,
    output logic [`DC_WAY_WIDTH-1:0]   o_way,
    output lsu_pkg::lsu_func_t         o_func,
    output logic [`LSU_ADDR_WIDTH-1:0] o_addr,
    output logic [`LSU_TAG_WIDTH-1:0]  o_tag,

    // APB access to the tag entries
    input  logic                       i_psel,
    input  logic                       i_penable,
    input  logic                       i_pwrite,
    input  logic [11:0]                i_paddr,
    input  logic [31:0]                i_pwdata,
    output logic [31:0]                o_prdata,
    output logic                       o_pready,

    // Miss requests to memory
    output logic                       o_miss_valid,
    output lsu_pkg::lsu_func_t         o_miss_func,
    output logic [`LSU_ADDR_WIDTH-1:0] o_miss_addr,
    output logic [`LSU_TAG_WIDTH-1:0]  o_miss_tag,
    input  logic                       i_miss_ready
);

    dc_tag_if dc_tag_bus ();
    mshq_if   mshq_bus ();

    lsu_hit hit_i (
        .clk       (clk),
        .i_reset   (i_reset),
        .i_valid   (i_valid),
        .i_func    (i_func),
        .i_addr    (i_addr),
        .i_tag     (i_tag),
        .o_valid   (o_valid),
        .o_outcome (o_outcome),
        .o_way     (o_way),
        .o_func    (o_func),
        .o_addr    (o_addr),
        .o_tag     (o_tag),
        .dc        (dc_tag_bus.lookup),
        .mq        (mshq_bus.requester)
    );

    dc_tag_array tag_array_i (
        .clk       (clk),
        .i_reset   (i_reset),
        .i_psel    (i_psel),
        .i_penable (i_penable),
        .i_pwrite  (i_pwrite),
        .i_paddr   (i_paddr),
        .i_pwdata  (i_pwdata),
        .o_prdata  (o_prdata),
        .o_pready  (o_pready),
        .tag       (dc_tag_bus.array)
    );

    mshq mshq_i (
        .clk          (clk),
        .i_reset      (i_reset),
        .o_miss_valid (o_miss_valid),
        .o_miss_func  (o_miss_func),
        .o_miss_addr  (o_miss_addr),
        .o_miss_tag   (o_miss_tag),
        .i_miss_ready (i_miss_ready),
        .q            (mshq_bus.queue)
    );

endmodule

// File: testbench/tb_lsu_dcache_lookup.sv
// Directed testbench for the D$ tag lookup stage with an APB driver and a miss port monitor
// A small model of the tags and the pending lines predicts every outcome and request
`timescale 1ns/1ps
`include "lsu_defs.svh"

module tb_lsu_dcache_lookup;

    localparam time drive_delay = 1;
    // All tests together take under a hundred cycles
    localparam int max_cycles = 2000;

    typedef struct packed {
        lsu_pkg::lsu_func_t func;
        logic [5:0]         tag;
        logic [31:0]        addr;
    } miss_t;

    logic clk;
    logic i_reset, i_valid, i_psel, i_penable, i_pwrite, i_miss_ready;
    lsu_pkg::lsu_func_t i_func;
    logic [31:0] i_addr, i_pwdata;
    logic [5:0]  i_tag;
    logic [11:0] i_paddr;
    logic o_valid, o_way, o_pready, o_miss_valid;
    lsu_pkg::lsu_outcome_t o_outcome;
    lsu_pkg::lsu_func_t o_func, o_miss_func;
    logic [31:0] o_addr, o_prdata, o_miss_addr;
    logic [5:0]  o_tag, o_miss_tag;

    // Model of the tag array and of the misses still waiting for memory
    logic        ref_valid [16][2];
    logic [22:0] ref_tag [16][2];
    bit          ref_written [16][2];
    miss_t       pend_q[$];

    logic [31:0] lfsr_state = 32'hcadd;
    int error_count = 0;
    int test_count = 0;
    int failed_tests = 0;
    int cycles = 0;

    lsu_dcache_lookup dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("Timeout: run did not finish within %0d cycles", max_cycles);
            $display("** FAIL **");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAILED %s: got %h expected %h", name, got, exp);
            error_count++;
        end
    endtask

    // A handshake seen mid-cycle transfers at the next rising edge
    always @(negedge clk) begin
        if (!i_reset && o_miss_valid && i_miss_ready) begin
            assert (pend_q.size() != 0) else begin
                $display("Memory request sent for addr %h with no miss pending", o_miss_addr);
                error_count++;
            end
            if (pend_q.size() != 0) begin
                check_value("o_miss_func", o_miss_func, pend_q[0].func);
                check_value("o_miss_addr", o_miss_addr, pend_q[0].addr);
                check_value("o_miss_tag", o_miss_tag, pend_q[0].tag);
                void'(pend_q.pop_front());
            end
        end
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic next_lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], next_lfsr_bit()};
        end
        return r;
    endfunction

    task automatic apb_write(input logic way, input logic [3:0] set, input logic valid,
                             input logic [22:0] tag_val);
        i_psel    = 1'b1;
        i_penable = 1'b0;
        i_pwrite  = 1'b1;
        i_paddr   = {5'd0, way, set, 2'b00};
        i_pwdata  = {valid, 8'd0, tag_val};
        @(posedge clk);
        #drive_delay i_penable = 1'b1;
        @(negedge clk);
        check_value("o_pready", o_pready, 32'd1);
        @(posedge clk);
        #drive_delay;
        i_psel    = 1'b0;
        i_penable = 1'b0;
        i_pwrite  = 1'b0;
        ref_valid[set][way]   = valid;
        ref_tag[set][way]     = tag_val;
        ref_written[set][way] = 1'b1;
    endtask

    task automatic apb_read(input logic way, input logic [3:0] set);
        i_psel    = 1'b1;
        i_penable = 1'b0;
        i_pwrite  = 1'b0;
        i_paddr   = {5'd0, way, set, 2'b00};
        @(posedge clk);
        #drive_delay i_penable = 1'b1;
        @(negedge clk);
        check_value("o_pready", o_pready, 32'd1);
        // Tag bits of an entry never written hold no defined value
        if (ref_written[set][way]) begin
            check_value("o_prdata", o_prdata, {ref_valid[set][way], 8'd0, ref_tag[set][way]});
        end else begin
            check_value("o_prdata[31]", o_prdata[31], 32'd0);
        end
        @(posedge clk);
        #drive_delay;
        i_psel    = 1'b0;
        i_penable = 1'b0;
    endtask

    task automatic lookup(input lsu_pkg::lsu_func_t func, input logic [31:0] addr,
                          input logic [5:0] itag);
        lsu_pkg::lsu_outcome_t exp_out;
        logic [3:0]  idx;
        logic [22:0] tg;
        logic        exp_way;
        logic        pending;
        idx     = addr[8:5];
        tg      = addr[31:9];
        exp_out = lsu_pkg::out_miss;
        exp_way = 1'b0;
        pending = 1'b0;
        for (int w = 0; w < 2; w++) begin
            if (ref_valid[idx][w] && ref_tag[idx][w] == tg) begin
                exp_out = lsu_pkg::out_hit;
                exp_way = w[0];
            end
        end
        foreach (pend_q[i]) begin
            if (pend_q[i].addr[31:5] == addr[31:5]) begin
                pending = 1'b1;
            end
        end
        if (exp_out != lsu_pkg::out_hit) begin
            if (pending) begin
                exp_out = lsu_pkg::out_merged;
            end else if (pend_q.size() == `MSHQ_DEPTH) begin
                exp_out = lsu_pkg::out_replay;
            end else begin
                pend_q.push_back('{func: func, tag: itag, addr: addr});
            end
        end
        i_valid = 1'b1;
        i_func  = func;
        i_addr  = addr;
        i_tag   = itag;
        @(posedge clk);
        #drive_delay i_valid = 1'b0;
        check_value("o_valid", o_valid, 32'd1);
        check_value("o_outcome", o_outcome, exp_out);
        if (exp_out == lsu_pkg::out_hit) begin
            check_value("o_way", o_way, exp_way);
        end
        check_value("o_func", o_func, func);
        check_value("o_addr", o_addr, addr);
        check_value("o_tag", o_tag, itag);
    endtask

    // Waits for memory to take every expected miss and then for a quiet port
    task automatic wait_drain();
        int n;
        n = 0;
        while (pend_q.size() != 0 && n < 40) begin
            @(posedge clk);
            #drive_delay n++;
        end
        assert (pend_q.size() == 0) else begin
            $display("%0d miss requests never reached memory", pend_q.size());
            error_count++;
        end
        repeat (3) @(posedge clk);
        #drive_delay check_value("o_miss_valid", o_miss_valid, 32'd0);
    endtask

    task automatic finish_test(input string name, input int errs_before);
        test_count++;
        if (error_count == errs_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, error_count - errs_before);
            failed_tests++;
        end
    endtask

    task automatic after_reset();
        int errs;
        errs = error_count;
        apb_read(1'b0, 4'd0);
        apb_read(1'b1, 4'd15);
        apb_read(1'b0, 4'd7);
        check_value("o_miss_valid", o_miss_valid, 32'd0);
        lookup(lsu_pkg::lsu_load, random_bits(32), 6'd1);
        wait_drain();
        finish_test("after_reset", errs);
    endtask

    task automatic tag_write_and_hit(output logic [22:0] t0);
        int errs;
        errs = error_count;
        t0 = random_bits(23);
        apb_write(1'b0, 4'd5, 1'b1, t0);
        apb_write(1'b1, 4'd5, 1'b1, t0 + 23'd1);
        apb_read(1'b0, 4'd5);
        apb_read(1'b1, 4'd5);
        lookup(lsu_pkg::lsu_load, {t0, 4'd5, 5'(random_bits(5))}, 6'd2);
        lookup(lsu_pkg::lsu_store, {t0 + 23'd1, 4'd5, 5'(random_bits(5))}, 6'd3);
        // Same set with a tag in neither way
        lookup(lsu_pkg::lsu_load, {t0 + 23'd2, 4'd5, 5'd0}, 6'd4);
        wait_drain();
        finish_test("tag_write_and_hit", errs);
    endtask

    task automatic primary_miss_send();
        int errs;
        errs = error_count;
        lookup(lsu_pkg::lsu_load, random_bits(32), 6'd10);
        lookup(lsu_pkg::lsu_store, random_bits(32), 6'd11);
        lookup(lsu_pkg::lsu_prefetch, random_bits(32), 6'd12);
        wait_drain();
        finish_test("primary_miss_send", errs);
    endtask

    task automatic secondary_miss_merge();
        int errs;
        logic [31:0] a;
        errs = error_count;
        a = {23'(random_bits(23)), 4'd6, 5'd4};
        i_miss_ready = 1'b0;
        lookup(lsu_pkg::lsu_load, a, 6'd20);
        lookup(lsu_pkg::lsu_load, {a[31:5], 5'd24}, 6'd21);
        repeat (2) @(posedge clk);
        #drive_delay check_value("o_miss_valid", o_miss_valid, 32'd1);
        check_value("o_miss_addr", o_miss_addr, a);
        i_miss_ready = 1'b1;
        wait_drain();
        finish_test("secondary_miss_merge", errs);
    endtask

    task automatic queue_full_replay(input logic [22:0] t0);
        int errs;
        logic [31:0] first;
        errs = error_count;
        i_miss_ready = 1'b0;
        first = {23'(random_bits(23)), 4'd8, 5'd0};
        lookup(lsu_pkg::lsu_load, first, 6'd30);
        for (int i = 9; i < 13; i++) begin
            lookup(lsu_pkg::lsu_store, {23'(random_bits(23)), i[3:0], 5'd8}, 6'(30 + i));
        end
        // Full queue leaves hits and merges unaffected
        lookup(lsu_pkg::lsu_load, {t0, 4'd5, 5'd12}, 6'd50);
        lookup(lsu_pkg::lsu_load, {first[31:5], 5'd16}, 6'd51);
        check_value("o_miss_addr", o_miss_addr, first);
        i_miss_ready = 1'b1;
        wait_drain();
        finish_test("queue_full_replay", errs);
    endtask

    initial begin
        logic [22:0] hit_tag;
        for (int s = 0; s < 16; s++) begin
            for (int w = 0; w < 2; w++) begin
                ref_valid[s][w]   = 1'b0;
                ref_tag[s][w]     = '0;
                ref_written[s][w] = 1'b0;
            end
        end
        i_reset      = 1'b1;
        i_valid      = 1'b0;
        i_func       = lsu_pkg::lsu_none;
        i_addr       = '0;
        i_tag        = '0;
        i_psel       = 1'b0;
        i_penable    = 1'b0;
        i_pwrite     = 1'b0;
        i_paddr      = '0;
        i_pwdata     = '0;
        i_miss_ready = 1'b1;
        repeat (5) @(posedge clk);
        #drive_delay i_reset = 1'b0;

        after_reset();
        tag_write_and_hit(hit_tag);
        primary_miss_send();
        secondary_miss_merge();
        queue_full_replay(hit_tag);

        $display("Tests run %0d, tests failed %0d, checks failed %0d",
                 test_count, failed_tests, error_count);
        if (error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+hdl
hdl/lsu_pkg.sv
hdl/lsu_ifs.sv
hdl/dc_tag_array.sv
hdl/mshq.sv
hdl/lsu_hit.sv
hdl/lsu_dcache_lookup.sv
testbench/tb_lsu_dcache_lookup.sv
